/* cop_defs.svh */
`ifndef COP_DEFS_SVH
`define COP_DEFS_SVH

// --------------------
// Instruction encoding

`define COP_OPCODE      7'b0001011      // custom-0 major opcode

`define COP_RD_LSB      7               // rd, bits 11..7
`define COP_FUNCT_LSB   12              // funct, bits 14..12
`define COP_CRS1_LSB    15              // crs1, bits 18..15
`define COP_CRS2_LSB    19              // crs2, bits 22..19
`define COP_PW_LSB      23              // Pack width, bits 24..23
`define COP_ZERO_LSB    25              // Must be zero, bits 31..25

// Function codes, 6 and 7 are reserved
`define COP_F_MV2GPR    3'd0
`define COP_F_MV2COP    3'd1
`define COP_F_ADD_PX    3'd2
`define COP_F_SUB_PX    3'd3
`define COP_F_CMOV      3'd4
`define COP_F_CMOVN     3'd5

// Pack width codes, 3 is reserved
`define COP_PW_32       2'd0
`define COP_PW_16       2'd1
`define COP_PW_8        2'd2

// --------------------
// Result codes and state size

`define COP_RES_OK      3'd0
`define COP_RES_INVALID 3'd1

`define COP_NUM_CPRS    16

`endif

/* cop_pkg.sv */
`include "cop_defs.svh"

package cop_pkg;

    // --------------------
    // Data and index types

    typedef logic [31:0] word_t;                            // GPR or CPR word
    typedef logic [$clog2(`COP_NUM_CPRS)-1:0] cpr_addr_t;   // CPR index
    typedef logic [4:0] gpr_addr_t;                         // GPR index
    typedef logic [`COP_NUM_CPRS-1:0] cpr_mask_t;           // One bit per CPR
    typedef logic [2:0] cop_result_t;                       // Execution result code

    // --------------------
    // Decoded operations

    typedef enum logic [2:0] {
        op_invalid = 3'd0,  // Anything the decoder rejects
        op_mv2gpr  = 3'd1,  // GPR <- crs1
        op_mv2cop  = 3'd2,  // crd <- rs1
        op_add_px  = 3'd3,  // Packed add
        op_sub_px  = 3'd4,  // Packed subtract
        op_cmov    = 3'd5,  // Move if crs2 nonzero
        op_cmovn   = 3'd6   // Move if crs2 zero
    } cop_op_e;

    // Lane widths for the packed arithmetic
    typedef enum logic [1:0] {
        pw_32 = `COP_PW_32,
        pw_16 = `COP_PW_16,
        pw_8  = `COP_PW_8
    } pack_width_e;

endpackage

/* cop_decode.sv */
`timescale 1ns/100ps

`include "cop_defs.svh"

module cop_decode (
    input  logic                  g_clk,
    input  logic                  g_resetn,

    input  logic                  cop_insn_valid,   // Instruction strobe
    input  cop_pkg::word_t        cop_insn_enc,     // Raw encoding
    input  cop_pkg::word_t        cop_rs1,          // GPR operand

    output logic                  dec_valid,        // One cycle per decoded instruction
    output cop_pkg::cop_op_e      dec_op,
    output cop_pkg::gpr_addr_t    dec_rd,
    output cop_pkg::cpr_addr_t    dec_crs1,
    output cop_pkg::cpr_addr_t    dec_crs2,
    output cop_pkg::pack_width_e  dec_pw,
    output cop_pkg::word_t        dec_rs1
);

    import cop_pkg::*;

    // --------------------
    // Field extraction

    logic [6:0]  f_opcode;
    logic [6:0]  f_zero;
    logic [2:0]  f_funct;
    logic [1:0]  f_pw;
    gpr_addr_t   f_rd;
    cpr_addr_t   f_crs1;
    cpr_addr_t   f_crs2;

    logic        hdr_ok;        // Opcode matches and reserved bits clear
    logic        pw_ok;         // Pack width code is legal
    pack_width_e pw_dec;
    cop_op_e     op_dec;

    assign f_opcode = cop_insn_enc[6:0];
    assign f_rd     = cop_insn_enc[`COP_RD_LSB +: 5];
    assign f_funct  = cop_insn_enc[`COP_FUNCT_LSB +: 3];
    assign f_crs1   = cop_insn_enc[`COP_CRS1_LSB +: 4];
    assign f_crs2   = cop_insn_enc[`COP_CRS2_LSB +: 4];
    assign f_pw     = cop_insn_enc[`COP_PW_LSB +: 2];
    assign f_zero   = cop_insn_enc[`COP_ZERO_LSB +: 7];

    assign hdr_ok = (f_opcode == `COP_OPCODE) && (f_zero == 7'd0);

    // Pack width, code 3 falls back to 32 bits and flags illegal
    always_comb
    begin
        pw_ok = 1'b1;
        case (f_pw)
            `COP_PW_32: pw_dec = pw_32;
            `COP_PW_16: pw_dec = pw_16;
            `COP_PW_8:  pw_dec = pw_8;
            default:
            begin
                pw_dec = pw_32;
                pw_ok  = 1'b0;
            end
        endcase
    end

    // Operation select
    always_comb
    begin
        op_dec = op_invalid;
        if (hdr_ok)
        begin
            case (f_funct)
                `COP_F_MV2GPR: op_dec = op_mv2gpr;
                `COP_F_MV2COP: op_dec = op_mv2cop;
                `COP_F_ADD_PX: op_dec = pw_ok ? op_add_px : op_invalid;
                `COP_F_SUB_PX: op_dec = pw_ok ? op_sub_px : op_invalid;
                `COP_F_CMOV:   op_dec = op_cmov;
                `COP_F_CMOVN:  op_dec = op_cmovn;
                default:       op_dec = op_invalid;     // Codes 6 and 7
            endcase
        end
    end

    // --------------------
    // Decode register

    always_ff @(posedge g_clk)
    begin
        if (!g_resetn)
        begin
            dec_valid <= 1'b0;
            dec_op    <= op_invalid;
        end
        else
        begin
            dec_valid <= cop_insn_valid;    // Drops on idle cycles
            if (cop_insn_valid)
                dec_op <= op_dec;
        end
    end

    // Operand fields, only loaded with a new instruction
    always_ff @(posedge g_clk)
    begin
        if (cop_insn_valid)
        begin
            dec_rd   <= f_rd;
            dec_crs1 <= f_crs1;
            dec_crs2 <= f_crs2;
            dec_pw   <= pw_dec;
            dec_rs1  <= cop_rs1;
        end
    end

endmodule

/* cop_cpr_file.sv */
`timescale 1ns/100ps

`include "cop_defs.svh"

module cop_cpr_file (
    input  logic                g_clk,
    input  logic                g_resetn,

    // Read ports, combinational
    input  cop_pkg::cpr_addr_t  crs1_addr,
    input  cop_pkg::cpr_addr_t  crs2_addr,
    output cop_pkg::word_t      crs1_data,
    output cop_pkg::word_t      crs2_data,

    // Write port, takes effect on the clock edge
    input  logic                cpr_wen,
    input  cop_pkg::cpr_addr_t  cpr_waddr,
    input  cop_pkg::word_t      cpr_wdata
);

    import cop_pkg::*;

    // --------------------
    // Register array

    word_t cprs [`COP_NUM_CPRS];

    always_ff @(posedge g_clk)
    begin
        if (!g_resetn)
        begin
            for (int i = 0; i < `COP_NUM_CPRS; i++)
                cprs[i] <= '0;                  // All CPRs start at zero
        end
        else if (cpr_wen)
        begin
            cprs[cpr_waddr] <= cpr_wdata;
        end
    end

    // --------------------
    // Read ports

    // No bypass. A write lands after the edge and is seen from the next cycle
    assign crs1_data = cprs[crs1_addr];
    assign crs2_data = cprs[crs2_addr];

endmodule

/* cop_execute.sv */
`timescale 1ns/100ps

`include "cop_defs.svh"

module cop_execute (
    input  logic                  g_clk,
    input  logic                  g_resetn,

    // From the decoder
    input  logic                  dec_valid,
    input  cop_pkg::cop_op_e      dec_op,
    input  cop_pkg::gpr_addr_t    dec_rd,
    input  cop_pkg::cpr_addr_t    dec_crs1,
    input  cop_pkg::cpr_addr_t    dec_crs2,
    input  cop_pkg::pack_width_e  dec_pw,
    input  cop_pkg::word_t        dec_rs1,

    // CPR read data
    input  cop_pkg::word_t        crs1_data,
    input  cop_pkg::word_t        crs2_data,

    // CPR write port
    output logic                  cpr_wen,
    output cop_pkg::cpr_addr_t    cpr_waddr,
    output cop_pkg::word_t        cpr_wdata,

    // Registered results
    output cop_pkg::cop_result_t  cop_result,
    output cop_pkg::cpr_mask_t    cop_cprs_read,
    output cop_pkg::cpr_mask_t    cop_cprs_written,
    output logic                  cop_rd_wen,
    output cop_pkg::gpr_addr_t    cop_rd_addr,
    output cop_pkg::word_t        cop_rd_data
);

    import cop_pkg::*;

    function automatic cpr_mask_t cpr_onehot(input cpr_addr_t addr);
        cpr_onehot = cpr_mask_t'(1) << addr;
    endfunction

    logic       px_sub;         // Subtract mode for the packed adder
    word_t      opb;            // Second adder operand
    logic [3:0] lane_start;     // Byte i begins a new lane
    word_t      px_sum;
    logic       crs2_nz;
    logic       cmov_take;      // Conditional move condition holds
    logic       wr_en_op;
    word_t      wr_data;
    cpr_mask_t  read_mask;
    logic       is_mv2gpr;

    // --------------------
    // Packed add and subtract

    // a - b as a + ~b + 1, with the +1 entering at every lane start
    assign px_sub = (dec_op == op_sub_px);
    assign opb    = px_sub ? ~crs2_data : crs2_data;

    assign lane_start[0] = 1'b1;
    assign lane_start[1] = (dec_pw == pw_8);
    assign lane_start[2] = (dec_pw != pw_32);
    assign lane_start[3] = (dec_pw == pw_8);

    always_comb
    begin
        logic [8:0] bsum;
        logic       carry;
        carry = px_sub;
        for (int i = 0; i < 4; i++)
        begin
            if (lane_start[i])
                carry = px_sub;                 // Break the chain at the lane edge
            bsum = {1'b0, crs1_data[8*i +: 8]} + {1'b0, opb[8*i +: 8]} + {8'd0, carry};
            px_sum[8*i +: 8] = bsum[7:0];
            carry = bsum[8];
        end
    end

    // --------------------
    // Conditional moves

    assign crs2_nz   = |crs2_data;
    assign cmov_take = ((dec_op == op_cmov) && crs2_nz) ||
                       ((dec_op == op_cmovn) && !crs2_nz);

    // Write data, write enable and read mask per operation
    always_comb
    begin
        wr_en_op  = 1'b0;
        wr_data   = crs1_data;
        read_mask = '0;
        case (dec_op)
            op_mv2gpr: read_mask = cpr_onehot(dec_crs1);
            op_mv2cop:
            begin
                wr_en_op = 1'b1;
                wr_data  = dec_rs1;             // GPR operand straight in
            end
            op_add_px, op_sub_px:
            begin
                wr_en_op  = 1'b1;
                wr_data   = px_sum;
                read_mask = cpr_onehot(dec_crs1) | cpr_onehot(dec_crs2);
            end
            op_cmov, op_cmovn:
            begin
                wr_en_op  = cmov_take;
                read_mask = cpr_onehot(dec_crs1) | cpr_onehot(dec_crs2);
            end
            default: wr_en_op = 1'b0;           // Invalid touches nothing
        endcase
    end

    assign cpr_wen   = dec_valid && wr_en_op;
    assign cpr_waddr = dec_rd[$bits(cpr_addr_t)-1:0];    // crd is the low bits of rd
    assign cpr_wdata = wr_data;

    assign is_mv2gpr = (dec_op == op_mv2gpr);

    // --------------------
    // Result registers

    always_ff @(posedge g_clk)
    begin
        if (!g_resetn)
        begin
            cop_result       <= `COP_RES_OK;
            cop_cprs_read    <= '0;
            cop_cprs_written <= '0;
            cop_rd_wen       <= 1'b0;
            cop_rd_addr      <= '0;
            cop_rd_data      <= '0;
        end
        else if (dec_valid)                     // Hold through idle cycles
        begin
            cop_result       <= (dec_op == op_invalid) ? `COP_RES_INVALID : `COP_RES_OK;
            cop_cprs_read    <= read_mask;
            cop_cprs_written <= cpr_wen ? cpr_onehot(cpr_waddr) : '0;
            cop_rd_wen       <= is_mv2gpr;
            cop_rd_addr      <= is_mv2gpr ? dec_rd : '0;
            cop_rd_data      <= is_mv2gpr ? crs1_data : '0;
        end
    end

endmodule

/* cop_ise.sv */
`timescale 1ns/100ps

module cop_ise (
    input  logic                  g_clk,
    input  logic                  g_resetn,

    // Instruction input
    input  logic                  cop_insn_valid,
    input  cop_pkg::word_t        cop_insn_enc,
    input  cop_pkg::word_t        cop_rs1,

    // Per-instruction results, two cycles after issue
    output cop_pkg::cop_result_t  cop_result,
    output cop_pkg::cpr_mask_t    cop_cprs_read,
    output cop_pkg::cpr_mask_t    cop_cprs_written,
    output logic                  cop_rd_wen,
    output cop_pkg::gpr_addr_t    cop_rd_addr,
    output cop_pkg::word_t        cop_rd_data
);

    import cop_pkg::*;

    // --------------------
    // Stage wiring

    logic        dec_valid;
    cop_op_e     dec_op;
    gpr_addr_t   dec_rd;
    cpr_addr_t   dec_crs1;
    cpr_addr_t   dec_crs2;
    pack_width_e dec_pw;
    word_t       dec_rs1;

    word_t       crs1_data;     // CPR file read data
    word_t       crs2_data;

    logic        cpr_wen;       // Execute stage writeback
    cpr_addr_t   cpr_waddr;
    word_t       cpr_wdata;

    // Decode stage
    cop_decode u_decode (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .cop_insn_valid (cop_insn_valid),
        .cop_insn_enc   (cop_insn_enc),
        .cop_rs1        (cop_rs1),
        .dec_valid      (dec_valid),
        .dec_op         (dec_op),
        .dec_rd         (dec_rd),
        .dec_crs1       (dec_crs1),
        .dec_crs2       (dec_crs2),
        .dec_pw         (dec_pw),
        .dec_rs1        (dec_rs1)
    );

    // Coprocessor register file
    cop_cpr_file u_cpr_file (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .crs1_addr (dec_crs1),
        .crs2_addr (dec_crs2),
        .crs1_data (crs1_data),
        .crs2_data (crs2_data),
        .cpr_wen   (cpr_wen),
        .cpr_waddr (cpr_waddr),
        .cpr_wdata (cpr_wdata)
    );

    // Execute stage
    cop_execute u_execute (
        .g_clk            (g_clk),
        .g_resetn         (g_resetn),
        .dec_valid        (dec_valid),
        .dec_op           (dec_op),
        .dec_rd           (dec_rd),
        .dec_crs1         (dec_crs1),
        .dec_crs2         (dec_crs2),
        .dec_pw           (dec_pw),
        .dec_rs1          (dec_rs1),
        .crs1_data        (crs1_data),
        .crs2_data        (crs2_data),
        .cpr_wen          (cpr_wen),
        .cpr_waddr        (cpr_waddr),
        .cpr_wdata        (cpr_wdata),
        .cop_result       (cop_result),
        .cop_cprs_read    (cop_cprs_read),
        .cop_cprs_written (cop_cprs_written),
        .cop_rd_wen       (cop_rd_wen),
        .cop_rd_addr      (cop_rd_addr),
        .cop_rd_data      (cop_rd_data)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic g_clk,
    output logic g_resetn
);

    initial
    begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;     // 20 ns period
    end

    // Reset held low for four rising edges
    initial
    begin
        g_resetn = 1'b0;
        repeat (4) @(posedge g_clk);
        #2 g_resetn = 1'b1;
    end

endmodule

/* tb_cop_ise.sv */
`timescale 1ns/100ps

`include "cop_defs.svh"

module tb_cop_ise;

    import cop_pkg::*;

    // Expected output state after one instruction, held over idle cycles
    typedef struct packed {
        cop_result_t result;
        cpr_mask_t   rmask;
        cpr_mask_t   wmask;
        logic        rd_wen;
        gpr_addr_t   rd_addr;
        word_t       rd_data;
    } exp_t;

    logic g_clk, g_resetn;
    logic cop_insn_valid;
    word_t cop_insn_enc, cop_rs1;
    cop_result_t cop_result;
    cpr_mask_t cop_cprs_read, cop_cprs_written;
    logic cop_rd_wen;
    gpr_addr_t cop_rd_addr;
    word_t cop_rd_data;

    integer seed;
    string  test_name;
    word_t  m_cpr [`COP_NUM_CPRS];  // Model CPR state
    exp_t   held;                   // Model output registers
    exp_t   exp_q [$];              // Two instructions in flight
    int     wait_cnt;
    gpr_addr_t rd_pick;             // Destination that is read back next

    tb_clock_gen u_clk (.g_clk(g_clk), .g_resetn(g_resetn));

    cop_ise UUT (.*);

    // --------------------
    // Helpers

    function automatic int unsigned urand(input int unsigned n);
        urand = $unsigned($random(seed)) % n;
    endfunction

    function automatic word_t encode(input logic [2:0] f, input gpr_addr_t rd,
                                     input cpr_addr_t c1, input cpr_addr_t c2,
                                     input logic [1:0] pw);
        encode = word_t'(`COP_OPCODE) | (word_t'(rd) << `COP_RD_LSB)
               | (word_t'(f) << `COP_FUNCT_LSB) | (word_t'(c1) << `COP_CRS1_LSB)
               | (word_t'(c2) << `COP_CRS2_LSB) | (word_t'(pw) << `COP_PW_LSB);
    endfunction

    // Lane-wise add or subtract, each lane masked on its own
    function automatic word_t lane_op(input word_t a, input word_t b, input int w,
                                      input logic sub);
        logic [31:0] m, la, lb, lr;
        lane_op = '0;
        m = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 1);
        for (int i = 0; i < 32; i += w)
        begin
            la = (a >> i) & m;
            lb = (b >> i) & m;
            lr = (sub ? la - lb : la + lb) & m;  // Wraps inside the lane
            lane_op = lane_op | (lr << i);
        end
    endfunction

    function automatic word_t rand_insn();
        word_t w;
        w = encode(urand(6), urand(32), urand(16), urand(16), urand(3));
        if (urand(8) == 0)
            w = $random(seed);                  // Occasional raw garbage
        return w;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Reference model, one instruction in program order
    task automatic model_issue(input word_t enc, input word_t rs1);
        logic [2:0] f;
        logic [1:0] pw;
        cpr_addr_t  c1, c2, crd;
        word_t      a, b, wdata;
        logic       ok, wen;
        f   = enc[`COP_FUNCT_LSB +: 3];
        pw  = enc[`COP_PW_LSB +: 2];
        c1  = enc[`COP_CRS1_LSB +: 4];
        c2  = enc[`COP_CRS2_LSB +: 4];
        crd = enc[`COP_RD_LSB +: 4];
        ok  = (enc[6:0] == `COP_OPCODE) && (enc[`COP_ZERO_LSB +: 7] == 7'd0) && (f <= 3'd5);
        if ((f == `COP_F_ADD_PX || f == `COP_F_SUB_PX) && pw == 2'd3)
            ok = 1'b0;
        a = m_cpr[c1];
        b = m_cpr[c2];
        wen = 1'b0;
        wdata = a;
        held = '0;
        held.result = ok ? `COP_RES_OK : `COP_RES_INVALID;
        if (ok)
        begin
            case (f)
                `COP_F_MV2GPR:
                begin
                    held.rmask   = 16'd1 << c1;
                    held.rd_wen  = 1'b1;
                    held.rd_addr = enc[`COP_RD_LSB +: 5];
                    held.rd_data = a;
                end
                `COP_F_MV2COP:
                begin
                    wen   = 1'b1;
                    wdata = rs1;
                end
                `COP_F_ADD_PX, `COP_F_SUB_PX:
                begin
                    held.rmask = (16'd1 << c1) | (16'd1 << c2);
                    wen   = 1'b1;
                    wdata = lane_op(a, b, (pw == 2'd2) ? 8 : (pw == 2'd1) ? 16 : 32,
                                    f == `COP_F_SUB_PX);
                end
                default:                        // cmov and cmovn
                begin
                    held.rmask = (16'd1 << c1) | (16'd1 << c2);
                    wen = (f == `COP_F_CMOV) ? (b != 0) : (b == 0);
                end
            endcase
        end
        if (wen)
        begin
            m_cpr[crd] = wdata;
            held.wmask = 16'd1 << crd;
        end
    endtask

    // One cycle: check outputs of two instructions back, then drive the next
    task automatic step(input logic valid, input word_t enc, input word_t rs1);
        exp_t e;
        @(posedge g_clk);
        #1;
        e = exp_q.pop_front();
        check({test_name, " result"}, e.result, cop_result);
        check({test_name, " cprs_read"}, e.rmask, cop_cprs_read);
        check({test_name, " cprs_written"}, e.wmask, cop_cprs_written);
        check({test_name, " rd_wen"}, e.rd_wen, cop_rd_wen);
        check({test_name, " rd_addr"}, e.rd_addr, cop_rd_addr);
        check({test_name, " rd_data"}, e.rd_data, cop_rd_data);
        #1;
        cop_insn_valid = valid;
        cop_insn_enc   = enc;
        cop_rs1        = rs1;
        if (valid)
            model_issue(enc, rs1);
        exp_q.push_back(held);
    endtask

    // --------------------
    // Stimulus

    initial
    begin
        cop_insn_valid = 1'b0;
        cop_insn_enc   = '0;
        cop_rs1        = '0;
        seed = 32'hb2ff_52ec;
        held = '0;
        for (int i = 0; i < `COP_NUM_CPRS; i++)
            m_cpr[i] = '0;
        exp_q = '{exp_t'(0), exp_t'(0)};        // Outputs read zero out of reset

        wait_cnt = 0;
        while (g_resetn !== 1'b1)
        begin
            @(posedge g_clk);
            wait_cnt++;
            if (wait_cnt > 50)
            begin
                $display("Reset was never released");
                $display("CHECKS FAILED");
                $fatal(1, "timeout");
            end
        end

        test_name = "reset";
        for (int i = 0; i < 16; i++)
            step(1'b1, encode(`COP_F_MV2GPR, i, i, 0, 0), $random(seed));

        test_name = "register_moves";
        for (int i = 0; i < 16; i++)
            step(1'b1, encode(`COP_F_MV2COP, i + 16 * urand(2), 0, 0, 0), $random(seed));
        for (int i = 0; i < 16; i++)
            step(1'b1, encode(`COP_F_MV2GPR, urand(32), i, 0, 0), $random(seed));

        test_name = "packed_add_sub";
        for (int pw = 0; pw < 3; pw++)
            for (int r = 0; r < 8; r++)
            begin
                rd_pick = urand(32);
                step(1'b1, encode(`COP_F_ADD_PX + r % 2, rd_pick, urand(16), urand(16), pw), 0);
                step(1'b1, encode(`COP_F_MV2GPR, urand(32), rd_pick[3:0], 0, 0), 0);  // Lanes
            end

        test_name = "cond_moves";
        step(1'b1, encode(`COP_F_MV2COP, 0, 0, 0, 0), 32'd0);                 // c0 = 0
        step(1'b1, encode(`COP_F_MV2COP, 1, 0, 0, 0), $random(seed) | 1);     // c1 != 0
        for (int r = 0; r < 8; r++)
        begin
            rd_pick = 2 + urand(14);
            step(1'b1, encode(`COP_F_CMOV + r % 2, rd_pick, urand(16), (r / 2) % 2, 0), 0);
            step(1'b1, encode(`COP_F_MV2GPR, urand(32), rd_pick[3:0], 0, 0), 0);
        end

        test_name = "invalid";
        step(1'b1, encode(`COP_F_MV2COP, 3, 0, 0, 0) ^ 32'h1, $random(seed)); // Bad opcode
        step(1'b1, encode(`COP_F_MV2COP, 4, 0, 0, 0) | (32'd1 << (`COP_ZERO_LSB + urand(7))), 1);
        step(1'b1, encode(3'd6, 5, 1, 2, 0), 0);
        step(1'b1, encode(3'd7, 6, 1, 2, 0), 0);
        step(1'b1, encode(`COP_F_ADD_PX, 7, 1, 2, 2'd3), 0);
        step(1'b1, encode(`COP_F_SUB_PX, 8, 1, 2, 2'd3), 0);
        for (int i = 0; i < 16; i++)
            step(1'b1, encode(`COP_F_MV2GPR, i, i, 0, 0), 0);     // Contents unchanged

        test_name = "random_stream";
        for (int n = 0; n < 400; n++)
            step(urand(4) != 0, rand_insn(), $random(seed));
        step(1'b0, '0, '0);                     // Drain the pipeline
        step(1'b0, '0, '0);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* cop_ise.f */
+incdir+.
cop_pkg.sv
cop_decode.sv
cop_cpr_file.sv
cop_execute.sv
cop_ise.sv
tb_clock_gen.sv
tb_cop_ise.sv

/* Bender.yml */
package:
  name: cop_ise

sources:
  - include_dirs:
      - .
    files:
      - cop_pkg.sv
      - cop_decode.sv
      - cop_cpr_file.sv
      - cop_execute.sv
      - cop_ise.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_cop_ise.sv
